// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  - files:
      - hw/rv_decode_pkg.sv
      - hw/mem_net_pkg.sv
      - hw/lsu.sv
      - hw/local_dmem.sv
      - hw/remote_apb_master.sv
      - hw/load_writeback.sv
      - hw/mem_stage.sv
  - target: test
    files:
      - tb/tb_mem_stage.sv

// ==== build.f ====
hw/rv_decode_pkg.sv
hw/mem_net_pkg.sv
hw/lsu.sv
hw/local_dmem.sv
hw/remote_apb_master.sv
hw/load_writeback.sv
hw/mem_stage.sv
tb/tb_mem_stage.sv

// ==== hw/load_writeback.sv ====
`timescale 1ns/1ns

module load_writeback (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  mem_net_pkg::load_rsp_s               local_rsp_i,
  input  mem_net_pkg::load_rsp_s               remote_rsp_i,
  output logic                                 wb_v_o,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [rv_decode_pkg::DATA_W-1:0]     wb_data_o
);

  mem_net_pkg::load_rsp_s               rsp;
  logic [rv_decode_pkg::DATA_W-1:0]     shifted;
  logic [rv_decode_pkg::DATA_W-1:0]     ext;
  logic [rv_decode_pkg::REG_ADDR_W-1:0] wb_rd_q;
  logic [rv_decode_pkg::DATA_W-1:0]     wb_data_q;

  // the two sources never land in the same cycle
  assign rsp     = local_rsp_i.valid ? local_rsp_i : remote_rsp_i;
  assign shifted = rsp.data >> {rsp.load_info.part_sel, 3'b000};

  always_comb begin
    case (rsp.load_info.size)
      rv_decode_pkg::SIZE_BYTE:
        ext = {{(rv_decode_pkg::DATA_W-8){~rsp.load_info.is_unsigned & shifted[7]}},
               shifted[7:0]};
      rv_decode_pkg::SIZE_HALF:
        ext = {{(rv_decode_pkg::DATA_W-16){~rsp.load_info.is_unsigned & shifted[15]}},
               shifted[15:0]};
      default:
        ext = shifted;
    endcase
  end

  // bus keeps the last write-back between loads
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      wb_rd_q   <= '0;
      wb_data_q <= '0;
    end else if (rsp.valid) begin
      wb_rd_q   <= rsp.rd;
      wb_data_q <= ext;
    end
  end

  assign wb_v_o    = rsp.valid;
  assign wb_rd_o   = rsp.valid ? rsp.rd : wb_rd_q;
  assign wb_data_o = rsp.valid ? ext : wb_data_q;

endmodule

// ==== hw/local_dmem.sv ====
`timescale 1ns/1ns

module local_dmem (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  mem_net_pkg::local_req_s               local_req_i,
  output mem_net_pkg::load_rsp_s                local_rsp_o,
  output logic                                  reserve_v_o,
  output logic [mem_net_pkg::DMEM_ADDR_W-1:0]   reserve_addr_o
);

  logic [rv_decode_pkg::DATA_W-1:0]     mem_q [mem_net_pkg::DMEM_WORDS];
  logic [rv_decode_pkg::DATA_W-1:0]     rdata_q;
  rv_decode_pkg::load_info_s            info_q;
  logic [rv_decode_pkg::REG_ADDR_W-1:0] rd_q;
  logic                                 rsp_v_q;
  logic                                 do_read;
  logic                                 do_write;

  assign do_read  = local_req_i.valid & ~local_req_i.write;
  assign do_write = local_req_i.valid & local_req_i.write;

  // byte lanes written under the mask
  always_ff @(posedge clk_i) begin
    if (do_write) begin
      for (int b = 0; b < rv_decode_pkg::MASK_W; b++) begin
        if (local_req_i.mask[b]) begin
          mem_q[local_req_i.addr][8*b +: 8] <= local_req_i.data[8*b +: 8];
        end
      end
    end
  end

  // sync read, info and rd ride along
  always_ff @(posedge clk_i) begin
    if (do_read) begin
      rdata_q <= mem_q[local_req_i.addr];
      info_q  <= local_req_i.load_info;
      rd_q    <= local_req_i.rd;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      rsp_v_q <= 1'b0;
    end else begin
      rsp_v_q <= do_read;
    end
  end

  assign local_rsp_o.valid     = rsp_v_q;
  assign local_rsp_o.data      = rdata_q;
  assign local_rsp_o.load_info = info_q;
  assign local_rsp_o.rd        = rd_q;

  // reservation, dropped by any store to that word
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      reserve_v_o    <= 1'b0;
      reserve_addr_o <= '0;
    end else if (do_read && local_req_i.reserve) begin
      reserve_v_o    <= 1'b1;
      reserve_addr_o <= local_req_i.addr;
    end else if (do_write && (local_req_i.addr == reserve_addr_o)) begin
      reserve_v_o <= 1'b0;
    end
  end

endmodule

// ==== hw/lsu.sv ====
`timescale 1ns/1ns

module lsu (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 op_v_i,
  input  rv_decode_pkg::decode_s               op_decode_i,
  input  logic [rv_decode_pkg::DATA_W-1:0]     op_rs1_i,
  input  logic [rv_decode_pkg::DATA_W-1:0]     op_rs2_i,
  input  logic [rv_decode_pkg::REG_ADDR_W-1:0] op_rd_i,
  input  logic [11:0]                          op_offset_i,
  input  logic                                 remote_busy_i,
  output logic                                 op_ready_o,
  output mem_net_pkg::local_req_s              local_req_o,
  output mem_net_pkg::remote_req_s             remote_req_o,
  output logic                                 remote_v_o
);

  logic [rv_decode_pkg::DATA_W-1:0] mem_addr;
  logic [rv_decode_pkg::DATA_W-1:0] store_data;
  logic [rv_decode_pkg::MASK_W-1:0] store_mask;
  rv_decode_pkg::load_info_s        load_info;
  logic                             is_local;
  logic                             is_store;
  logic                             accept;
  logic                             live_q;

  // no issue until the first clock after reset
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      live_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
    end
  end

  assign op_ready_o = live_q & ~remote_busy_i;
  assign accept     = op_v_i & op_ready_o;

  // effective address
  assign mem_addr = op_rs1_i
    + {{(rv_decode_pkg::DATA_W-12){op_offset_i[11]}}, op_offset_i};

  // replicate store data, mask picks the lanes
  always_comb begin
    case (op_decode_i.size)
      rv_decode_pkg::SIZE_BYTE: begin
        store_data = {4{op_rs2_i[7:0]}};
        store_mask = rv_decode_pkg::MASK_W'(1) << mem_addr[1:0];
      end
      rv_decode_pkg::SIZE_HALF: begin
        store_data = {2{op_rs2_i[15:0]}};
        store_mask = mem_addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        store_data = op_rs2_i;
        store_mask = 4'b1111;
      end
    endcase
  end

  assign is_local = ~|mem_addr[rv_decode_pkg::DATA_W-1:mem_net_pkg::LOCAL_WINDOW_BITS];
  assign is_store = (op_decode_i.op == rv_decode_pkg::OP_STORE);

  always_comb begin
    load_info.is_unsigned = op_decode_i.is_unsigned;
    load_info.size        = op_decode_i.size;
    load_info.part_sel    = mem_addr[1:0];
  end

  // local side, LR is a read that also reserves
  always_comb begin
    local_req_o.valid     = accept & is_local;
    local_req_o.write     = is_store;
    local_req_o.reserve   = (op_decode_i.op == rv_decode_pkg::OP_LR);
    local_req_o.addr      = mem_addr[2 +: mem_net_pkg::DMEM_ADDR_W];
    local_req_o.data      = store_data;
    local_req_o.mask      = store_mask;
    local_req_o.load_info = load_info;
    local_req_o.rd        = op_rd_i;
  end

  // everything outside the window goes remote
  always_comb begin
    remote_req_o.write_not_read = is_store;
    remote_req_o.addr           = mem_addr;
    remote_req_o.data           = store_data;
    remote_req_o.mask           = store_mask;
    remote_req_o.load_info      = load_info;
    remote_req_o.rd             = op_rd_i;
  end

  assign remote_v_o = accept & ~is_local;

endmodule

// ==== hw/mem_net_pkg.sv ====
package mem_net_pkg;

  // local window is the low 4 KB
  localparam int LOCAL_WINDOW_BITS = 12;
  localparam int DMEM_WORDS        = 1024;
  localparam int DMEM_ADDR_W       = 10;

  // request to the local data memory
  typedef struct packed {
    logic                                 valid;
    logic                                 write;
    logic                                 reserve;
    logic [DMEM_ADDR_W-1:0]               addr;
    logic [rv_decode_pkg::DATA_W-1:0]     data;
    logic [rv_decode_pkg::MASK_W-1:0]     mask;
    rv_decode_pkg::load_info_s            load_info;
    logic [rv_decode_pkg::REG_ADDR_W-1:0] rd;
  } local_req_s;

  // request leaving through the APB port
  typedef struct packed {
    logic                                 write_not_read;
    logic [rv_decode_pkg::DATA_W-1:0]     addr;
    logic [rv_decode_pkg::DATA_W-1:0]     data;
    logic [rv_decode_pkg::MASK_W-1:0]     mask;
    rv_decode_pkg::load_info_s            load_info;
    logic [rv_decode_pkg::REG_ADDR_W-1:0] rd;
  } remote_req_s;

  // raw load word with its extraction info
  typedef struct packed {
    logic                                 valid;
    logic [rv_decode_pkg::DATA_W-1:0]     data;
    rv_decode_pkg::load_info_s            load_info;
    logic [rv_decode_pkg::REG_ADDR_W-1:0] rd;
  } load_rsp_s;

  typedef struct packed {
    logic [rv_decode_pkg::DATA_W-1:0] paddr;
    logic                             psel;
    logic                             penable;
    logic                             pwrite;
    logic [rv_decode_pkg::DATA_W-1:0] pwdata;
    logic [rv_decode_pkg::MASK_W-1:0] pstrb;
  } apb_req_s;

  typedef struct packed {
    logic [rv_decode_pkg::DATA_W-1:0] prdata;
    logic                             pready;
    logic                             pslverr;
  } apb_rsp_s;

endpackage

// ==== hw/mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 op_v_i,
  input  rv_decode_pkg::decode_s               op_decode_i,
  input  logic [rv_decode_pkg::DATA_W-1:0]     op_rs1_i,
  input  logic [rv_decode_pkg::DATA_W-1:0]     op_rs2_i,
  input  logic [rv_decode_pkg::REG_ADDR_W-1:0] op_rd_i,
  input  logic [11:0]                          op_offset_i,
  output logic                                 op_ready_o,
  output mem_net_pkg::apb_req_s                apb_req_o,
  input  mem_net_pkg::apb_rsp_s                apb_rsp_i,
  output logic                                 wb_v_o,
  output logic [rv_decode_pkg::REG_ADDR_W-1:0] wb_rd_o,
  output logic [rv_decode_pkg::DATA_W-1:0]     wb_data_o,
  output logic                                 remote_err_o,
  output logic                                 reserve_v_o,
  output logic [mem_net_pkg::DMEM_ADDR_W-1:0]  reserve_addr_o
);

  mem_net_pkg::local_req_s  local_req;
  mem_net_pkg::remote_req_s remote_req;
  mem_net_pkg::load_rsp_s   local_rsp;
  mem_net_pkg::load_rsp_s   remote_rsp;
  logic                     remote_v;
  logic                     remote_busy;

  lsu lsu_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .op_v_i        (op_v_i),
    .op_decode_i   (op_decode_i),
    .op_rs1_i      (op_rs1_i),
    .op_rs2_i      (op_rs2_i),
    .op_rd_i       (op_rd_i),
    .op_offset_i   (op_offset_i),
    .remote_busy_i (remote_busy),
    .op_ready_o    (op_ready_o),
    .local_req_o   (local_req),
    .remote_req_o  (remote_req),
    .remote_v_o    (remote_v)
  );

  local_dmem local_dmem_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .local_req_i    (local_req),
    .local_rsp_o    (local_rsp),
    .reserve_v_o    (reserve_v_o),
    .reserve_addr_o (reserve_addr_o)
  );

  remote_apb_master remote_apb_master_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .remote_v_i    (remote_v),
    .remote_req_i  (remote_req),
    .remote_busy_o (remote_busy),
    .apb_req_o     (apb_req_o),
    .apb_rsp_i     (apb_rsp_i),
    .remote_rsp_o  (remote_rsp),
    .remote_err_o  (remote_err_o)
  );

  load_writeback load_writeback_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .local_rsp_i  (local_rsp),
    .remote_rsp_i (remote_rsp),
    .wb_v_o       (wb_v_o),
    .wb_rd_o      (wb_rd_o),
    .wb_data_o    (wb_data_o)
  );

endmodule

// ==== hw/remote_apb_master.sv ====
`timescale 1ns/1ns

module remote_apb_master (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     remote_v_i,
  input  mem_net_pkg::remote_req_s remote_req_i,
  output logic                     remote_busy_o,
  output mem_net_pkg::apb_req_s    apb_req_o,
  input  mem_net_pkg::apb_rsp_s    apb_rsp_i,
  output mem_net_pkg::load_rsp_s   remote_rsp_o,
  output logic                     remote_err_o
);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } state_e;

  state_e                   state_q;
  mem_net_pkg::remote_req_s req_q;
  logic                     done;
  logic                     rsp_v_q;
  logic [rv_decode_pkg::DATA_W-1:0] rsp_data_q;

  // transfer ends on the first ready access cycle
  assign done = (state_q == ACCESS) & apb_rsp_i.pready;

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (remote_v_i) state_q <= SETUP;
        SETUP:   state_q <= ACCESS;
        ACCESS:  if (apb_rsp_i.pready) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // request held stable for the whole transfer
  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && remote_v_i) begin
      req_q <= remote_req_i;
    end
  end

  assign remote_busy_o = (state_q != IDLE);

  always_comb begin
    apb_req_o.paddr   = req_q.addr;
    apb_req_o.psel    = (state_q != IDLE);
    apb_req_o.penable = (state_q == ACCESS);
    apb_req_o.pwrite  = req_q.write_not_read;
    apb_req_o.pwdata  = req_q.data;
    // reads take the whole word
    apb_req_o.pstrb   = req_q.write_not_read ? req_q.mask : '0;
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      rsp_v_q      <= 1'b0;
      remote_err_o <= 1'b0;
    end else begin
      rsp_v_q      <= done & ~req_q.write_not_read & ~apb_rsp_i.pslverr;
      remote_err_o <= done & apb_rsp_i.pslverr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (done) begin
      rsp_data_q <= apb_rsp_i.prdata;
    end
  end

  assign remote_rsp_o.valid     = rsp_v_q;
  assign remote_rsp_o.data      = rsp_data_q;
  assign remote_rsp_o.load_info = req_q.load_info;
  assign remote_rsp_o.rd        = req_q.rd;

endmodule

// ==== hw/rv_decode_pkg.sv ====
package rv_decode_pkg;

  // datapath widths
  localparam int DATA_W     = 32;
  localparam int MASK_W     = DATA_W / 8;
  localparam int REG_ADDR_W = 5;

  // memory operation kind
  typedef enum logic [1:0] {
    OP_LOAD,
    OP_STORE,
    OP_LR
  } mem_op_e;

  // access size
  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } mem_size_e;

  // decoded memory operation from the core
  typedef struct packed {
    mem_op_e   op;
    mem_size_e size;
    logic      is_unsigned;
  } decode_s;

  // what a load result needs to be extracted
  typedef struct packed {
    logic      is_unsigned;
    mem_size_e size;
    logic [1:0] part_sel;
  } load_info_s;

endpackage

// ==== tb/tb_mem_stage.sv ====
`timescale 1ns/1ns

module tb_mem_stage;

  localparam int MAX_WAIT = 3;
  localparam int NUM_OPS  = 40;
  // issue, setup, access, waits and write-back per op plus reset
  localparam int CYCLE_LIMIT = 20 + NUM_OPS * (MAX_WAIT + 6);
  localparam logic [31:0] ERR_ADDR = 32'h0002_0040;
  localparam logic [31:0] SEED     = 32'hfc00_ca49;

  logic                          clk_i;
  logic                          reset_i;
  logic                          op_v_i;
  rv_decode_pkg::decode_s        op_decode_i;
  logic [31:0]                   op_rs1_i;
  logic [31:0]                   op_rs2_i;
  logic [4:0]                    op_rd_i;
  logic [11:0]                   op_offset_i;
  logic                          op_ready_o;
  mem_net_pkg::apb_req_s         apb_req_o;
  mem_net_pkg::apb_rsp_s         apb_rsp_i;
  logic                          wb_v_o;
  logic [4:0]                    wb_rd_o;
  logic [31:0]                   wb_data_o;
  logic                          remote_err_o;
  logic                          reserve_v_o;
  logic [9:0]                    reserve_addr_o;

  logic [31:0]           local_model [int];
  logic [31:0]           remote_mem [logic [29:0]];
  logic [31:0]           wait_rng;
  logic [31:0]           data_rng;
  int                    wait_left;
  int                    cycle_cnt;
  int                    pready_cycle;
  mem_net_pkg::apb_req_s last_xfer;
  int                    check_count;
  int                    err_count;

  mem_stage mem_stage_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .op_v_i         (op_v_i),
    .op_decode_i    (op_decode_i),
    .op_rs1_i       (op_rs1_i),
    .op_rs2_i       (op_rs2_i),
    .op_rd_i        (op_rd_i),
    .op_offset_i    (op_offset_i),
    .op_ready_o     (op_ready_o),
    .apb_req_o      (apb_req_o),
    .apb_rsp_i      (apb_rsp_i),
    .wb_v_o         (wb_v_o),
    .wb_rd_o        (wb_rd_o),
    .wb_data_o      (wb_data_o),
    .remote_err_o   (remote_err_o),
    .reserve_v_o    (reserve_v_o),
    .reserve_addr_o (reserve_addr_o)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] eff_addr(input logic [31:0] rs1, input logic [11:0] off);
    return rs1 + {{20{off[11]}}, off};
  endfunction

  function automatic logic [3:0] lane_mask(input rv_decode_pkg::mem_size_e size,
                                           input logic [1:0] a);
    logic [3:0] m;
    for (int i = 0; i < 4; i++) begin
      case (size)
        rv_decode_pkg::SIZE_BYTE: m[i] = (i == a);
        rv_decode_pkg::SIZE_HALF: m[i] = ((i / 2) == a[1]);
        default:                  m[i] = 1'b1;
      endcase
    end
    return m;
  endfunction

  // each lane carries the byte of the access that lands there
  function automatic logic [31:0] replicate(input rv_decode_pkg::mem_size_e size,
                                            input logic [31:0] d);
    logic [31:0] r;
    for (int i = 0; i < 4; i++) begin
      case (size)
        rv_decode_pkg::SIZE_BYTE: r[8*i +: 8] = d[7:0];
        rv_decode_pkg::SIZE_HALF: r[8*i +: 8] = d[8*(i % 2) +: 8];
        default:                  r[8*i +: 8] = d[8*i +: 8];
      endcase
    end
    return r;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] d,
                                              input logic [3:0] m);
    logic [31:0] r;
    r = old;
    for (int i = 0; i < 4; i++) begin
      if (m[i]) r[8*i +: 8] = d[8*i +: 8];
    end
    return r;
  endfunction

  function automatic logic [31:0] extend_load(input logic [31:0] word,
                                              input rv_decode_pkg::mem_size_e size,
                                              input logic uns, input logic [1:0] part);
    logic [31:0] s;
    s = word >> (8 * part);
    case (size)
      rv_decode_pkg::SIZE_BYTE: return uns ? {24'b0, s[7:0]} : {{24{s[7]}}, s[7:0]};
      rv_decode_pkg::SIZE_HALF: return uns ? {16'b0, s[15:0]} : {{16{s[15]}}, s[15:0]};
      default:                  return s;
    endcase
  endfunction

  // untouched remote words read as a pattern of the full address
  function automatic logic [31:0] remote_word(input logic [31:0] a);
    if (remote_mem.exists(a[31:2])) return remote_mem[a[31:2]];
    return {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
  endfunction

  function automatic rv_decode_pkg::decode_s make_decode(input rv_decode_pkg::mem_op_e op,
                                                         input rv_decode_pkg::mem_size_e size,
                                                         input logic uns);
    rv_decode_pkg::decode_s d;
    d.op          = op;
    d.size        = size;
    d.is_unsigned = uns;
    return d;
  endfunction

  // apb slave with random wait states
  always @(negedge clk_i) begin
    apb_rsp_i.pready  = 1'b0;
    apb_rsp_i.pslverr = 1'b0;
    if (apb_req_o.psel && !apb_req_o.penable) begin
      wait_rng  = xorshift32(wait_rng);
      wait_left = wait_rng % (MAX_WAIT + 1);
    end else if (apb_req_o.psel && apb_req_o.penable) begin
      if (wait_left > 0) begin
        wait_left--;
      end else begin
        apb_rsp_i.pready  = 1'b1;
        apb_rsp_i.pslverr = (apb_req_o.paddr[31:2] == ERR_ADDR[31:2]);
        apb_rsp_i.prdata  = remote_word(apb_req_o.paddr);
        if (apb_req_o.pwrite && !apb_rsp_i.pslverr) begin
          remote_mem[apb_req_o.paddr[31:2]] = merge_bytes(remote_word(apb_req_o.paddr),
                                                          apb_req_o.pwdata, apb_req_o.pstrb);
        end
        last_xfer    = apb_req_o;
        pready_cycle = cycle_cnt;
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      err_count++;
      $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("%s: %s", name, (err_count == errs_before) ? "ok" : "failed");
  endtask

  // returns at the falling edge of the cycle after acceptance
  task automatic issue_op(input rv_decode_pkg::decode_s dec, input logic [31:0] rs1,
                          input logic [31:0] rs2, input logic [4:0] rd,
                          input logic [11:0] off);
    @(negedge clk_i);
    op_v_i      = 1'b1;
    op_decode_i = dec;
    op_rs1_i    = rs1;
    op_rs2_i    = rs2;
    op_rd_i     = rd;
    op_offset_i = off;
    while (!op_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    @(negedge clk_i);
    op_v_i = 1'b0;
  endtask

  task automatic local_store(input rv_decode_pkg::mem_size_e size, input logic [31:0] rs1,
                             input logic [31:0] rs2, input logic [11:0] off);
    logic [31:0] addr;
    logic [31:0] old;
    addr = eff_addr(rs1, off);
    issue_op(make_decode(rv_decode_pkg::OP_STORE, size, 1'b0), rs1, rs2, 5'd0, off);
    old = local_model.exists(int'(addr[11:2])) ? local_model[int'(addr[11:2])] : 32'h0;
    local_model[int'(addr[11:2])] = merge_bytes(old, replicate(size, rs2),
                                                lane_mask(size, addr[1:0]));
    check_value("wb_v_o after store", wb_v_o, 1'b0);
  endtask

  task automatic local_load(input rv_decode_pkg::mem_op_e op,
                            input rv_decode_pkg::mem_size_e size, input logic uns,
                            input logic [31:0] rs1, input logic [11:0] off,
                            input logic [4:0] rd);
    logic [31:0] addr;
    addr = eff_addr(rs1, off);
    issue_op(make_decode(op, size, uns), rs1, 32'h0, rd, off);
    check_value("wb_v_o", wb_v_o, 1'b1);
    check_value("wb_rd_o", wb_rd_o, rd);
    check_value("wb_data_o", wb_data_o,
                extend_load(local_model[int'(addr[11:2])], size, uns, addr[1:0]));
  endtask

  // setup in the cycle after acceptance, access next, stall until one cycle after pready
  task automatic finish_remote();
    check_value("op_ready_o during transfer", op_ready_o, 1'b0);
    check_value("apb_req_o.psel in setup", apb_req_o.psel, 1'b1);
    check_value("apb_req_o.penable in setup", apb_req_o.penable, 1'b0);
    @(negedge clk_i);
    check_value("apb_req_o.psel in access", apb_req_o.psel, 1'b1);
    check_value("apb_req_o.penable in access", apb_req_o.penable, 1'b1);
    while (!op_ready_o) @(negedge clk_i);
    check_value("op_ready_o rise cycle", cycle_cnt, pready_cycle + 1);
    check_value("apb_req_o.psel after transfer", apb_req_o.psel, 1'b0);
    check_value("apb_req_o.penable after transfer", apb_req_o.penable, 1'b0);
  endtask

  task automatic remote_store(input rv_decode_pkg::mem_size_e size, input logic [31:0] rs1,
                              input logic [31:0] rs2, input logic [11:0] off);
    logic [31:0] addr;
    addr = eff_addr(rs1, off);
    issue_op(make_decode(rv_decode_pkg::OP_STORE, size, 1'b0), rs1, rs2, 5'd0, off);
    finish_remote();
    check_value("paddr", last_xfer.paddr, addr);
    check_value("pwrite", last_xfer.pwrite, 1'b1);
    check_value("pstrb", last_xfer.pstrb, lane_mask(size, addr[1:0]));
    check_value("pwdata", last_xfer.pwdata, replicate(size, rs2));
    check_value("wb_v_o after remote store", wb_v_o, 1'b0);
  endtask

  task automatic remote_load(input rv_decode_pkg::mem_size_e size, input logic uns,
                             input logic [31:0] rs1, input logic [11:0] off,
                             input logic [4:0] rd);
    logic [31:0] addr;
    addr = eff_addr(rs1, off);
    issue_op(make_decode(rv_decode_pkg::OP_LOAD, size, uns), rs1, 32'h0, rd, off);
    finish_remote();
    check_value("paddr", last_xfer.paddr, addr);
    check_value("pstrb on read", last_xfer.pstrb, 4'b0000);
    check_value("wb_v_o", wb_v_o, 1'b1);
    check_value("wb_rd_o", wb_rd_o, rd);
    check_value("wb_data_o", wb_data_o, extend_load(remote_word(addr), size, uns, addr[1:0]));
  endtask

  task automatic test_local_word();
    int errs;
    errs = err_count;
    local_store(rv_decode_pkg::SIZE_WORD, 32'h0000_0080, 32'hdead_beef, 12'h010);
    local_load(rv_decode_pkg::OP_LOAD, rv_decode_pkg::SIZE_WORD, 1'b0,
               32'h0000_0090, 12'h000, 5'd3);
    report_test("local word store/load", errs);
  endtask

  task automatic test_local_subword();
    logic [7:0]  bytes [4] = '{8'h81, 8'h7e, 8'hf0, 8'h3c};
    logic [15:0] halves [2] = '{16'h8a01, 16'h7f55};
    int errs;
    errs = err_count;
    local_store(rv_decode_pkg::SIZE_WORD, 32'h0000_0200, 32'h0, 12'h000);
    for (int i = 0; i < 4; i++) begin
      local_store(rv_decode_pkg::SIZE_BYTE, 32'h0000_0200, {24'h0, bytes[i]}, 12'(i));
    end
    for (int i = 0; i < 4; i++) begin
      local_load(rv_decode_pkg::OP_LOAD, rv_decode_pkg::SIZE_BYTE, 1'b0,
                 32'h0000_0200, 12'(i), 5'(10 + i));
      local_load(rv_decode_pkg::OP_LOAD, rv_decode_pkg::SIZE_BYTE, 1'b1,
                 32'h0000_0200, 12'(i), 5'(20 + i));
    end
    local_store(rv_decode_pkg::SIZE_WORD, 32'h0000_0204, 32'h0, 12'h000);
    for (int i = 0; i < 2; i++) begin
      local_store(rv_decode_pkg::SIZE_HALF, 32'h0000_0204, {16'h0, halves[i]}, 12'(2 * i));
    end
    for (int i = 0; i < 2; i++) begin
      local_load(rv_decode_pkg::OP_LOAD, rv_decode_pkg::SIZE_HALF, 1'b0,
                 32'h0000_0204, 12'(2 * i), 5'(5 + i));
      local_load(rv_decode_pkg::OP_LOAD, rv_decode_pkg::SIZE_HALF, 1'b1,
                 32'h0000_0204, 12'(2 * i), 5'(15 + i));
    end
    report_test("local byte/half access", errs);
  endtask

  task automatic test_remote_store();
    int errs;
    errs = err_count;
    remote_store(rv_decode_pkg::SIZE_BYTE, 32'h0001_0000, 32'h1234_56ab, 12'h7fd);
    // negative offset
    remote_store(rv_decode_pkg::SIZE_HALF, 32'h0002_1004, 32'h0000_c3d2, 12'hffe);
    remote_store(rv_decode_pkg::SIZE_WORD, 32'h0003_0000, 32'h0bad_f00d, 12'h008);
    report_test("remote store", errs);
  endtask

  task automatic test_remote_load();
    rv_decode_pkg::mem_size_e sizes [4];
    logic                     uns [4] = '{1'b0, 1'b1, 1'b0, 1'b1};
    logic [1:0]               part;
    int                       errs;
    errs  = err_count;
    sizes = '{rv_decode_pkg::SIZE_BYTE, rv_decode_pkg::SIZE_HALF,
              rv_decode_pkg::SIZE_WORD, rv_decode_pkg::SIZE_BYTE};
    // read back a byte written by the remote store test
    remote_load(rv_decode_pkg::SIZE_BYTE, 1'b0, 32'h0001_07fc, 12'h001, 5'd9);
    for (int i = 0; i < 4; i++) begin
      data_rng = xorshift32(data_rng);
      case (sizes[i])
        rv_decode_pkg::SIZE_BYTE: part = data_rng[1:0];
        rv_decode_pkg::SIZE_HALF: part = {data_rng[1], 1'b0};
        default:                  part = 2'b00;
      endcase
      remote_load(sizes[i], uns[i], 32'h0010_0000 | (data_rng & 32'h0000_fff0),
                  {10'b0, part}, 5'(24 + i));
    end
    report_test("remote load", errs);
  endtask

  task automatic test_reservation();
    int errs;
    errs = err_count;
    local_store(rv_decode_pkg::SIZE_WORD, 32'h0000_0100, 32'h1234_5678, 12'h000);
    local_load(rv_decode_pkg::OP_LR, rv_decode_pkg::SIZE_WORD, 1'b0,
               32'h0000_0100, 12'h000, 5'd7);
    check_value("reserve_v_o after LR", reserve_v_o, 1'b1);
    check_value("reserve_addr_o", reserve_addr_o, 10'h040);
    local_store(rv_decode_pkg::SIZE_WORD, 32'h0000_0104, 32'h0000_0001, 12'h000);
    check_value("reserve_v_o after other store", reserve_v_o, 1'b1);
    check_value("reserve_addr_o", reserve_addr_o, 10'h040);
    local_store(rv_decode_pkg::SIZE_BYTE, 32'h0000_0100, 32'h0000_005e, 12'h002);
    check_value("reserve_v_o after same-word store", reserve_v_o, 1'b0);
    report_test("load-reserve", errs);
  endtask

  task automatic test_remote_error();
    int errs;
    errs = err_count;
    issue_op(make_decode(rv_decode_pkg::OP_LOAD, rv_decode_pkg::SIZE_WORD, 1'b0),
             ERR_ADDR, 32'h0, 5'd12, 12'h000);
    finish_remote();
    check_value("remote_err_o", remote_err_o, 1'b1);
    check_value("wb_v_o on error", wb_v_o, 1'b0);
    @(negedge clk_i);
    check_value("remote_err_o pulse end", remote_err_o, 1'b0);
    issue_op(make_decode(rv_decode_pkg::OP_STORE, rv_decode_pkg::SIZE_WORD, 1'b0),
             ERR_ADDR, 32'h5555_aaaa, 5'd0, 12'h000);
    finish_remote();
    check_value("remote_err_o", remote_err_o, 1'b1);
    check_value("wb_v_o on error", wb_v_o, 1'b0);
    report_test("remote error", errs);
  endtask

  initial begin
    clk_i        = 1'b0;
    reset_i      = 1'b0;
    op_v_i       = 1'b0;
    op_decode_i  = '0;
    op_rs1_i     = '0;
    op_rs2_i     = '0;
    op_rd_i      = '0;
    op_offset_i  = '0;
    apb_rsp_i    = '0;
    wait_rng     = SEED;
    data_rng     = SEED;
    wait_left    = 0;
    cycle_cnt    = 0;
    pready_cycle = 0;
    check_count  = 0;
    err_count    = 0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b1;
    check_value("apb_req_o.psel after reset", apb_req_o.psel, 1'b0);
    check_value("apb_req_o.penable after reset", apb_req_o.penable, 1'b0);
    check_value("wb_v_o after reset", wb_v_o, 1'b0);
    check_value("remote_err_o after reset", remote_err_o, 1'b0);
    check_value("reserve_v_o after reset", reserve_v_o, 1'b0);
    test_local_word();
    test_local_subword();
    test_remote_store();
    test_remote_load();
    test_reservation();
    test_remote_error();
    $display("checks: %0d run, %0d failed", check_count, err_count);
    if (err_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
